/* rv_pipe_pkg.sv */
package rv_pipe_pkg;

    // Widths fixed by the RV64 integer ISA.
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]       xlen_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand source selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,  // Register file read port.
        FWD_EX  = 2'd1,  // Result of the instruction in EX.
        FWD_MEM = 2'd2,  // Result of the instruction in MEM, load data included.
        FWD_WB  = 2'd3   // Value being written back.
    } fwd_src_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // In-flight instruction records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Destination of one instruction, 8 bits.
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      we;
        logic      is_load;
    } dest_rec_t;

    // Decode-stage request, 18 bits.
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        dest_rec_t dest;
    } src_req_t;

endpackage

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv_pipe_pkg::reg_addr_t rs1,
    input  rv_pipe_pkg::reg_addr_t rs2,
    input  rv_pipe_pkg::dest_rec_t wb_rec,
    input  rv_pipe_pkg::xlen_t     wb_data,
    output rv_pipe_pkg::xlen_t     rf1,
    output rv_pipe_pkg::xlen_t     rf2,
    output logic                  wb_en
);

    // x0 has no storage.
    rv_pipe_pkg::xlen_t regs [1:31];

    // Reads see a write of the same cycle.
    function automatic rv_pipe_pkg::xlen_t read_port(input rv_pipe_pkg::reg_addr_t addr);
        rv_pipe_pkg::xlen_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wb_en && (wb_rec.rd == addr)) begin
            val = wb_data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    assign wb_en = wb_rec.valid & wb_rec.we & (wb_rec.rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rec.rd] <= wb_data;
        end
    end

    always_comb begin
        rf1 = read_port(rs1);
        rf2 = read_port(rs2);
    end

endmodule

/* dest_tracker.sv */
`timescale 1ns/1ps

module dest_tracker (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  issue_valid,
    input  rv_pipe_pkg::dest_rec_t issue_dest,
    input  logic                  stall,
    output rv_pipe_pkg::dest_rec_t ex_rec,
    output rv_pipe_pkg::dest_rec_t mem_rec,
    output rv_pipe_pkg::dest_rec_t wb_rec
);

    logic                  accept;
    rv_pipe_pkg::dest_rec_t ex_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue into EX
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign accept = issue_valid & ~stall;

    // A held or absent request leaves a bubble behind in EX.
    always_comb begin
        if (accept) begin
            ex_next = issue_dest;
        end else begin
            ex_next = '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // MEM and WB advance even during a stall.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_rec  <= '0;
            mem_rec <= '0;
            wb_rec  <= '0;
        end else begin
            ex_rec  <= ex_next;
            mem_rec <= ex_rec;
            wb_rec  <= mem_rec;  // Leaves the pipe after this cycle.
        end
    end

endmodule

/* hazard_detect.sv */
`timescale 1ns/1ps

module hazard_detect (
    input  logic                  issue_valid,
    input  rv_pipe_pkg::reg_addr_t rs1,
    input  rv_pipe_pkg::reg_addr_t rs2,
    input  rv_pipe_pkg::dest_rec_t ex_rec,
    input  rv_pipe_pkg::dest_rec_t mem_rec,
    input  rv_pipe_pkg::dest_rec_t wb_rec,
    output logic                  stall,
    output rv_pipe_pkg::fwd_src_e  fwd1,
    output rv_pipe_pkg::fwd_src_e  fwd2
);

    logic load_use1;
    logic load_use2;

    // A record only produces a value if it writes a real register.
    function automatic logic rec_match(input rv_pipe_pkg::dest_rec_t rec,
                                       input rv_pipe_pkg::reg_addr_t rs);
        return rec.valid & rec.we & (rec.rd != '0) & (rec.rd == rs);
    endfunction

    // Youngest producer wins.
    function automatic rv_pipe_pkg::fwd_src_e pick_src(input rv_pipe_pkg::reg_addr_t rs);
        rv_pipe_pkg::fwd_src_e src;
        if (rec_match(ex_rec, rs)) begin
            src = rv_pipe_pkg::FWD_EX;
        end else if (rec_match(mem_rec, rs)) begin
            src = rv_pipe_pkg::FWD_MEM;
        end else if (rec_match(wb_rec, rs)) begin
            src = rv_pipe_pkg::FWD_WB;
        end else begin
            src = rv_pipe_pkg::FWD_RF;
        end
        return src;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load-use detection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Load data is not ready until MEM.
    assign load_use1 = rec_match(ex_rec, rs1) & ex_rec.is_load;
    assign load_use2 = rec_match(ex_rec, rs2) & ex_rec.is_load;

    assign stall = issue_valid & (load_use1 | load_use2);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Forwarding choice
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        fwd1 = pick_src(rs1);
        fwd2 = pick_src(rs2);  // Stays FWD_EX on a load hit, stall masks it.
    end

endmodule

/* operand_select.sv */
`timescale 1ns/1ps

module operand_select (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 issue_valid,
    input  logic                 stall,
    input  rv_pipe_pkg::fwd_src_e fwd1,
    input  rv_pipe_pkg::fwd_src_e fwd2,
    input  rv_pipe_pkg::xlen_t    rf1,
    input  rv_pipe_pkg::xlen_t    rf2,
    input  rv_pipe_pkg::xlen_t    ex_res,
    input  rv_pipe_pkg::xlen_t    mem_res,
    input  rv_pipe_pkg::xlen_t    wb_data,
    output logic                 op_valid,
    output rv_pipe_pkg::xlen_t    op1,
    output rv_pipe_pkg::xlen_t    op2
);

    logic               accept;
    rv_pipe_pkg::xlen_t op1_next;
    rv_pipe_pkg::xlen_t op2_next;

    function automatic rv_pipe_pkg::xlen_t fwd_mux(input rv_pipe_pkg::fwd_src_e src,
                                                   input rv_pipe_pkg::xlen_t    rf);
        rv_pipe_pkg::xlen_t val;
        case (src)
            rv_pipe_pkg::FWD_EX:  val = ex_res;
            rv_pipe_pkg::FWD_MEM: val = mem_res;
            rv_pipe_pkg::FWD_WB:  val = wb_data;
            default:              val = rf;
        endcase
        return val;
    endfunction

    assign accept = issue_valid & ~stall;

    always_comb begin
        op1_next = fwd_mux(fwd1, rf1);
        op2_next = fwd_mux(fwd2, rf2);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ID/EX operand register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= accept;  // One pulse per accepted issue.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op1 <= op1_next;
            op2 <= op2_next;
        end
    end

endmodule

/* id_operand_unit.sv */
`timescale 1ns/1ps

module id_operand_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   issue_valid,
    input  rv_pipe_pkg::src_req_t   issue,
    input  rv_pipe_pkg::xlen_t      ex_res,
    input  rv_pipe_pkg::xlen_t      mem_res,
    input  rv_pipe_pkg::xlen_t      wb_data,
    output logic                   stall,
    output logic                   op_valid,
    output rv_pipe_pkg::xlen_t      op1,
    output rv_pipe_pkg::xlen_t      op2,
    output logic                   wb_en,
    output rv_pipe_pkg::reg_addr_t  wb_rd
);

    rv_pipe_pkg::dest_rec_t ex_rec;
    rv_pipe_pkg::dest_rec_t mem_rec;
    rv_pipe_pkg::dest_rec_t wb_rec;
    rv_pipe_pkg::fwd_src_e  fwd1;
    rv_pipe_pkg::fwd_src_e  fwd2;
    rv_pipe_pkg::xlen_t     rf1;
    rv_pipe_pkg::xlen_t     rf2;

    assign wb_rd = wb_rec.rd;  // Qualified by wb_en.

    regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1     (issue.rs1),
        .rs2     (issue.rs2),
        .wb_rec  (wb_rec),
        .wb_data (wb_data),
        .rf1     (rf1),
        .rf2     (rf2),
        .wb_en   (wb_en)
    );

    dest_tracker u_dest_tracker (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_dest  (issue.dest),
        .stall       (stall),
        .ex_rec      (ex_rec),
        .mem_rec     (mem_rec),
        .wb_rec      (wb_rec)
    );

    hazard_detect u_hazard_detect (
        .issue_valid (issue_valid),
        .rs1         (issue.rs1),
        .rs2         (issue.rs2),
        .ex_rec      (ex_rec),
        .mem_rec     (mem_rec),
        .wb_rec      (wb_rec),
        .stall       (stall),
        .fwd1        (fwd1),
        .fwd2        (fwd2)
    );

    operand_select u_operand_select (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .stall       (stall),
        .fwd1        (fwd1),
        .fwd2        (fwd2),
        .rf1         (rf1),
        .rf2         (rf2),
        .ex_res      (ex_res),
        .mem_res     (mem_res),
        .wb_data     (wb_data),
        .op_valid    (op_valid),
        .op1         (op1),
        .op2         (op2)
    );

endmodule

/* id_operand_unit_assertions.sv */
`timescale 1ns/1ps

module id_operand_unit_assertions (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   issue_valid,
    input logic                   stall,
    input logic                   op_valid,
    input logic                   wb_en,
    input rv_pipe_pkg::reg_addr_t wb_rd
);

    int fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stall and issue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    stall_needs_issue: assert property (
        @(posedge clk) disable iff (!arst_n) stall |-> issue_valid
    ) else begin
        fail_count++;
        $error("stall is high without a request in decode");
    end

    // A held request must not produce operands.
    no_op_after_stall: assert property (
        @(posedge clk) disable iff (!arst_n) stall |=> !op_valid
    ) else begin
        fail_count++;
        $error("op_valid rose for a request that was stalled");
    end

    no_x0_write: assert property (
        @(posedge clk) disable iff (!arst_n) wb_en |-> (wb_rd != '0)
    ) else begin
        fail_count++;
        $error("register file write to x0");
    end

endmodule

/* tb_id_operand_unit.sv */
`timescale 1ns/1ps

module tb_id_operand_unit;

    // Long enough for 200 random issues with stalls and idle gaps, plus the directed tests.
    localparam int MAX_CYCLES = 2000;

    // Model of one pipeline stage, with the value it produces.
    typedef struct packed {
        logic                   valid;
        rv_pipe_pkg::reg_addr_t rd;
        logic                   we;
        logic                   is_load;
        rv_pipe_pkg::xlen_t     val;
    } stage_t;

    logic                   clk;
    logic                   arst_n;
    logic                   issue_valid;
    rv_pipe_pkg::src_req_t  issue;
    rv_pipe_pkg::xlen_t     ex_res;
    rv_pipe_pkg::xlen_t     mem_res;
    rv_pipe_pkg::xlen_t     wb_data;
    logic                   stall;
    logic                   op_valid;
    rv_pipe_pkg::xlen_t     op1;
    rv_pipe_pkg::xlen_t     op2;
    logic                   wb_en;
    rv_pipe_pkg::reg_addr_t wb_rd;

    rv_pipe_pkg::xlen_t mrf [0:31];
    stage_t             pipe [0:2];  // Index 0 is EX, 1 is MEM, 2 is WB.
    integer             seed = 32'hcfbd704f;
    int                 cycle_count = 0;

    id_operand_unit dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .ex_res      (ex_res),
        .mem_res     (mem_res),
        .wb_data     (wb_data),
        .stall       (stall),
        .op_valid    (op_valid),
        .op1         (op1),
        .op2         (op2),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd)
    );

    bind id_operand_unit id_operand_unit_assertions u_assertions (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .stall       (stall),
        .op_valid    (op_valid),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("tests failed");
            $fatal(1);
        end
    end

    always @(dut0.u_assertions.fail_count) begin
        if (dut0.u_assertions.fail_count != 0) begin
            $display("An assertion in the bound checker failed.");
            $display("tests failed");
            $fatal(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic rv_pipe_pkg::xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic stage_match(input stage_t s, input rv_pipe_pkg::reg_addr_t rs);
        return s.valid && s.we && (s.rd != 0) && (s.rd == rs);
    endfunction

    // EX beats MEM beats WB beats the register file.
    function automatic rv_pipe_pkg::xlen_t expect_operand(input rv_pipe_pkg::reg_addr_t rs);
        if (rs == 0) return '0;
        if (stage_match(pipe[0], rs)) return pipe[0].val;
        if (stage_match(pipe[1], rs)) return pipe[1].val;
        if (stage_match(pipe[2], rs)) return pipe[2].val;
        return mrf[rs];
    endfunction

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h got %h", name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // One clock cycle, starting right after a falling edge.
    task automatic run_cycle(input logic v, input rv_pipe_pkg::src_req_t req,
                             output logic accepted);
        logic               exp_stall;
        logic               exp_wb_en;
        rv_pipe_pkg::xlen_t exp1;
        rv_pipe_pkg::xlen_t exp2;
        stage_t             fresh;
        issue_valid = v;
        issue       = req;
        ex_res      = pipe[0].is_load ? ~pipe[0].val : pipe[0].val;  // Load data is not ready.
        mem_res     = pipe[1].val;
        wb_data     = pipe[2].val;
        exp_stall   = v && pipe[0].is_load &&
                      (stage_match(pipe[0], req.rs1) || stage_match(pipe[0], req.rs2));
        exp_wb_en   = pipe[2].valid && pipe[2].we && (pipe[2].rd != 0);
        exp1        = expect_operand(req.rs1);
        exp2        = expect_operand(req.rs2);
        accepted    = v && !exp_stall;
        #10;
        check_eq("stall", exp_stall, stall);
        check_eq("wb_en", exp_wb_en, wb_en);
        if (exp_wb_en) check_eq("wb_rd", pipe[2].rd, wb_rd);
        @(posedge clk);
        if (exp_wb_en) mrf[pipe[2].rd] = pipe[2].val;
        pipe[2] = pipe[1];
        pipe[1] = pipe[0];
        fresh = '0;
        if (accepted) begin
            fresh.valid   = 1'b1;
            fresh.rd      = req.dest.rd;
            fresh.we      = req.dest.we;
            fresh.is_load = req.dest.is_load;
        end
        fresh.val = rand64();  // Bubbles carry noise too, so a wrong forward shows.
        pipe[0] = fresh;
        @(negedge clk);
        check_eq("op_valid", accepted, op_valid);
        if (accepted) begin
            check_eq("op1", exp1, op1);
            check_eq("op2", exp2, op2);
        end
    endtask

    task automatic idle(input int n);
        logic dummy;
        repeat (n) run_cycle(1'b0, '0, dummy);
    endtask

    // A negative exp_stalls skips the stall count check.
    task automatic issue_instr(input rv_pipe_pkg::reg_addr_t rs1, input rv_pipe_pkg::reg_addr_t rs2,
                               input rv_pipe_pkg::reg_addr_t rd, input logic we,
                               input logic is_load, input int exp_stalls);
        rv_pipe_pkg::src_req_t req;
        logic                  accepted;
        int                    stalls;
        req       = '0;
        req.rs1   = rs1;
        req.rs2   = rs2;
        req.dest  = '{valid: 1'b1, rd: rd, we: we, is_load: is_load};
        stalls    = 0;
        accepted  = 1'b0;
        while (!accepted) begin
            run_cycle(1'b1, req, accepted);
            if (!accepted) stalls++;
        end
        if (exp_stalls >= 0) check_eq("stall_cycles", exp_stalls, stalls);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_rf_reads();
        for (int k = 1; k <= 6; k++) issue_instr(0, 0, k, 1'b1, 1'b0, 0);
        idle(3);  // Drain, so reads see only the register file.
        issue_instr(1, 2, 0, 1'b0, 1'b0, 0);
        issue_instr(3, 4, 0, 1'b0, 1'b0, 0);
        issue_instr(5, 6, 0, 1'b0, 1'b0, 0);
        issue_instr(0, 1, 0, 1'b0, 1'b0, 0);
    endtask

    task automatic test_ex_forward();
        issue_instr(1, 2, 5, 1'b1, 1'b0, 0);
        issue_instr(5, 0, 0, 1'b0, 1'b0, 0);
        issue_instr(3, 5, 7, 1'b1, 1'b0, 0);
        issue_instr(7, 7, 0, 1'b0, 1'b0, 0);
    endtask

    task automatic test_mem_wb_forward();
        issue_instr(0, 0, 6, 1'b1, 1'b0, 0);
        issue_instr(0, 0, 0, 1'b0, 1'b0, 0);
        issue_instr(6, 1, 0, 1'b0, 1'b0, 0);  // Producer in MEM.
        issue_instr(0, 0, 7, 1'b1, 1'b0, 0);
        issue_instr(0, 0, 0, 1'b0, 1'b0, 0);
        issue_instr(0, 0, 0, 1'b0, 1'b0, 0);
        issue_instr(2, 7, 0, 1'b0, 1'b0, 0);  // Producer in WB.
        issue_instr(0, 0, 8, 1'b1, 1'b0, 0);
        issue_instr(0, 0, 8, 1'b1, 1'b0, 0);
        issue_instr(8, 8, 0, 1'b0, 1'b0, 0);  // EX and MEM both hold x8.
    endtask

    task automatic test_load_use();
        issue_instr(1, 0, 9, 1'b1, 1'b1, 0);
        issue_instr(9, 2, 0, 1'b0, 1'b0, 1);
        issue_instr(3, 0, 10, 1'b1, 1'b1, 0);
        issue_instr(4, 10, 0, 1'b0, 1'b0, 1);
        issue_instr(10, 9, 0, 1'b0, 1'b0, 0);
    endtask

    task automatic test_no_forward();
        issue_instr(0, 0, 0, 1'b1, 1'b0, 0);
        issue_instr(0, 0, 0, 1'b0, 1'b0, 0);
        issue_instr(0, 0, 0, 1'b1, 1'b1, 0);  // Load to x0.
        issue_instr(0, 0, 0, 1'b0, 1'b0, 0);
        issue_instr(0, 0, 11, 1'b0, 1'b1, 0);
        issue_instr(11, 11, 0, 1'b0, 1'b0, 0);
        issue_instr(0, 0, 13, 1'b1, 1'b0, 0);
        idle(3);
        issue_instr(13, 13, 0, 1'b0, 1'b0, 0);
        issue_instr(0, 0, 14, 1'b1, 1'b1, 0);
        issue_instr(14, 0, 0, 1'b0, 1'b0, 1);  // Leaves a bubble in EX.
        issue_instr(0, 14, 0, 1'b0, 1'b0, 0);
    endtask

    task automatic test_random_mix();
        rv_pipe_pkg::reg_addr_t rs1;
        rv_pipe_pkg::reg_addr_t rs2;
        rv_pipe_pkg::reg_addr_t rd;
        logic                   we;
        logic                   ld;
        for (int i = 0; i < 200; i++) begin
            if (($random(seed) & 7) == 0) idle(1);
            rs1 = $random(seed) & 7;  // Few registers, many hazards.
            rs2 = $random(seed) & 7;
            rd  = $random(seed) & 7;
            we  = ($random(seed) & 3) != 0;
            ld  = ($random(seed) & 3) == 0;
            issue_instr(rs1, rs2, rd, we, ld, -1);
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        ex_res      = '0;
        mem_res     = '0;
        wb_data     = '0;
        for (int i = 0; i < 32; i++) mrf[i] = '0;
        for (int i = 0; i < 3; i++) pipe[i] = '0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        test_rf_reads();
        test_ex_forward();
        test_mem_wb_forward();
        test_load_use();
        test_no_forward();
        test_random_mix();
        idle(4);
        $display("all tests passed");
        $finish;
    end

endmodule

/* sim.f */
rv_pipe_pkg.sv
regfile.sv
dest_tracker.sv
hazard_detect.sv
operand_select.sv
id_operand_unit.sv
id_operand_unit_assertions.sv
tb_id_operand_unit.sv
